//--- src/lsu_config_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Address map and default sizing of the load/store subsystem
////////////////////////////////////////////////////////////////////////////

package lsu_config_pkg;

    // Address bit that splits the two targets
    // Set means external bus, clear means scratch memory
    localparam int BUS_REGION_BIT = 31;

    // Scratch RAM size in 32-bit words
    localparam int DEFAULT_SCRATCH_WORDS = 256;

    // Input queue depth, requests accepted ahead of issue
    localparam int DEFAULT_INFLIGHT = 4;

    // Cycles to wait for bus ack before giving up
    localparam int DEFAULT_BUS_TIMEOUT = 64;

    // Issued requests waiting for completion
    // Bounds how many accesses are in flight at once
    localparam int ATTR_DEPTH = 2;

endpackage

//--- src/lsu_types_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Data types shared by the load/store unit and its targets
////////////////////////////////////////////////////////////////////////////

package lsu_types_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [3:0] ls_id_t;

    // Access width, same encoding as the fn3 field
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_BU = 3'd4,
        LS_HU = 3'd5
    } ls_width_t;

    // Request as it arrives on the issue port
    typedef struct packed {
        addr_t     addr;
        word_t     store_data;
        ls_width_t width;
        ls_id_t    id;
        logic      load;
        logic      store;
        logic      forward;
    } ls_request_t;

    // Request broadcast to every target
    typedef struct packed {
        addr_t    addr;
        byte_en_t be;
        word_t    wdata;
        logic     load;
        logic     store;
    } sub_request_t;

    // Target response, rdata is zero unless data_valid
    typedef struct packed {
        word_t rdata;
        logic  data_valid;
        logic  ready;
        logic  error;
    } sub_response_t;

    typedef struct packed {
        ls_id_t id;
        word_t  rd;
        logic   done;
        logic   error;
    } ls_writeback_t;

    // Command held on the external bus while req is high
    typedef struct packed {
        addr_t    addr;
        byte_en_t be;
        word_t    wdata;
        logic     we;
    } bus_cmd_t;

endpackage

//--- src/lsu_fifo.sv
`timescale 1ns/10ps

module lsu_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] data_in,
    input  logic             push,
    input  logic             pop,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             empty,
    output logic             full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer step, wraps at DEPTH so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    // Ignore push when full and pop when empty
    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    // Head entry always visible
    assign data_out = entries[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign valid = ~empty;

endmodule

//--- src/bus_timeout_timer.sv
`timescale 1ns/10ps

module bus_timeout_timer
    import lsu_config_pkg::*;
#(
    parameter int TIMEOUT = DEFAULT_BUS_TIMEOUT
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);
    localparam int CNT_W = $clog2(TIMEOUT + 1);

    logic [CNT_W-1:0] count;

    // Restart whenever run drops
    // Saturates at TIMEOUT so expired holds
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == CNT_W'(TIMEOUT));

endmodule

//--- src/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit
    import lsu_config_pkg::*, lsu_types_pkg::*;
#(
    parameter int INFLIGHT = DEFAULT_INFLIGHT
) (
    input  logic          clk,
    input  logic          rst,
    input  ls_request_t   request,
    input  logic          request_valid,
    output logic          request_ready,
    output sub_request_t  sub_req,
    output logic          scratch_new_request,
    output logic          bus_new_request,
    input  sub_response_t scratch_rsp,
    input  sub_response_t bus_rsp,
    output ls_writeback_t wb
);
    // What the completion side needs to know about an issued request
    typedef struct packed {
        ls_width_t width;
        logic [1:0] offset;
        ls_id_t id;
        logic is_store;
        logic error;
    } ls_attr_t;

    ls_request_t stage1;
    ls_attr_t    attr_in;
    ls_attr_t    head;
    logic        in_valid, in_full;
    logic        attr_valid, attr_empty, attr_full;
    logic        is_bus, last_bus, misaligned, target_ready;
    logic        issue;
    logic        unit_done, load_done, store_done, misalign_done, complete;
    word_t       store_src, unit_rdata, aligned, final_data, previous_load;
    byte_en_t    be;

    ////////////////////////////////////////////////////////////////////////////
    // Input queue
    lsu_fifo #(.WIDTH($bits(ls_request_t)), .DEPTH(INFLIGHT)) input_queue (
        .clk(clk), .rst(rst), .data_in(request), .push(request_valid & request_ready),
        .pop(issue), .data_out(stage1), .valid(in_valid), .empty(), .full(in_full)
    );
    assign request_ready = ~in_full;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and issue
    assign is_bus = stage1.addr[BUS_REGION_BIT];

    // Halfwords on even bytes, words on word boundaries
    always_comb begin
        case (stage1.width)
            LS_H, LS_HU: misaligned = stage1.addr[0];
            LS_W: misaligned = |stage1.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Target of everything in the attribute queue
    always_ff @(posedge clk) begin
        if (rst) begin
            last_bus <= 1'b0;
        end else if (issue) begin
            last_bus <= is_bus;
        end
    end

    assign target_ready = is_bus ? bus_rsp.ready : scratch_rsp.ready;

    // Target switch, forwarding store and misaligned requests drain the queue first
    // Keeps writebacks in issue order
    assign issue = in_valid & ~attr_full
        & ~((is_bus != last_bus) & ~attr_empty)
        & ~(stage1.store & stage1.forward & ~attr_empty)
        & ~(misaligned & ~attr_empty)
        & (misaligned | target_ready);

    assign scratch_new_request = issue & ~misaligned & ~is_bus;
    assign bus_new_request = issue & ~misaligned & is_bus;

    ////////////////////////////////////////////////////////////////////////////
    // Store path
    always_comb begin
        case (stage1.width[1:0])
            2'b00: be = byte_en_t'(4'b0001 << stage1.addr[1:0]);
            2'b01: be = stage1.addr[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
        // No lanes for loads
        be &= {4{stage1.store}};
    end

    assign store_src = stage1.forward ? previous_load : stage1.store_data;

    // Replicate byte or halfword into every lane, be picks the real one
    always_comb begin
        case (stage1.width[1:0])
            2'b00: sub_req.wdata = {4{store_src[7:0]}};
            2'b01: sub_req.wdata = {2{store_src[15:0]}};
            default: sub_req.wdata = store_src;
        endcase
    end

    assign sub_req.addr = stage1.addr;
    assign sub_req.be = be;
    assign sub_req.load = stage1.load;
    assign sub_req.store = stage1.store;

    ////////////////////////////////////////////////////////////////////////////
    // Attribute queue
    assign attr_in.width = stage1.width;
    assign attr_in.offset = stage1.addr[1:0];
    assign attr_in.id = stage1.id;
    assign attr_in.is_store = stage1.store;
    assign attr_in.error = misaligned;

    lsu_fifo #(.WIDTH($bits(ls_attr_t)), .DEPTH(ATTR_DEPTH)) attr_queue (
        .clk(clk), .rst(rst), .data_in(attr_in), .push(issue), .pop(complete),
        .data_out(head), .valid(attr_valid), .empty(attr_empty), .full(attr_full)
    );

    // Scratch stores finish the cycle after issue, bus reports its own end
    assign unit_done = scratch_rsp.data_valid | bus_rsp.data_valid;
    assign store_done = attr_valid & head.is_store & ~head.error & ~last_bus;
    assign misalign_done = attr_valid & head.error;
    assign complete = unit_done | store_done | misalign_done;
    assign load_done = unit_done & ~head.is_store & ~bus_rsp.error;

    ////////////////////////////////////////////////////////////////////////////
    // Load data
    // Idle targets return zero
    assign unit_rdata = scratch_rsp.rdata | bus_rsp.rdata;
    assign aligned = unit_rdata >> {head.offset, 3'b000};

    always_comb begin
        case (head.width)
            LS_B: final_data = {{24{aligned[7]}}, aligned[7:0]};
            LS_H: final_data = {{16{aligned[15]}}, aligned[15:0]};
            LS_BU: final_data = {24'd0, aligned[7:0]};
            LS_HU: final_data = {16'd0, aligned[15:0]};
            default: final_data = aligned;
        endcase
    end

    // Source for forwarding stores
    always_ff @(posedge clk) begin
        if (load_done) begin
            previous_load <= final_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    assign wb.id = head.id;
    assign wb.rd = load_done ? final_data : '0;
    assign wb.done = complete;
    assign wb.error = head.error | bus_rsp.error;

endmodule

//--- src/scratch_mem.sv
`timescale 1ns/10ps

module scratch_mem
    import lsu_config_pkg::*, lsu_types_pkg::*;
#(
    parameter int WORDS = DEFAULT_SCRATCH_WORDS
) (
    input  logic          clk,
    input  logic          rst,
    input  sub_request_t  sub_req,
    input  logic          new_request,
    output sub_response_t rsp
);
    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    word_t            mem [WORDS];
    logic [IDX_W-1:0] idx;
    word_t            rdata_q;
    logic             valid_q;

    // Word address wraps around the RAM
    assign idx = IDX_W'(sub_req.addr[31:2] % WORDS);

    // Byte-enable write
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (new_request && sub_req.store && sub_req.be[i]) begin
                mem[idx][8*i +: 8] <= sub_req.wdata[8*i +: 8];
            end
        end
        if (new_request && sub_req.load) begin
            rdata_q <= mem[idx];
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= new_request & sub_req.load;
        end
    end

    // Zero when idle so results can be ORed
    assign rsp.rdata = valid_q ? rdata_q : '0;
    assign rsp.data_valid = valid_q;
    assign rsp.ready = 1'b1;
    assign rsp.error = 1'b0;

endmodule

//--- src/bus_master.sv
`timescale 1ns/10ps

module bus_master
    import lsu_config_pkg::*, lsu_types_pkg::*;
#(
    parameter int TIMEOUT = DEFAULT_BUS_TIMEOUT
) (
    input  logic          clk,
    input  logic          rst,
    input  sub_request_t  sub_req,
    input  logic          new_request,
    output sub_response_t rsp,
    output bus_cmd_t      bus_cmd,
    output logic          bus_req,
    input  logic          bus_ack,
    input  word_t         bus_rdata
);
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        DONE
    } bus_state_t;

    bus_state_t state;
    bus_cmd_t   cmd_q;
    word_t      rdata_q;
    logic       load_q;
    logic       err_q;
    logic       expired;

    // Only counts while waiting on ack
    bus_timeout_timer #(.TIMEOUT(TIMEOUT)) ack_timer (
        .clk(clk), .rst(rst), .run((state == REQ) & ~bus_ack), .expired(expired)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                IDLE: if (new_request) begin
                    state <= REQ;
                    err_q <= 1'b0;
                end
                // Ack wins over a same-cycle expiry
                REQ: if (bus_ack) begin
                    state <= RELEASE;
                end else if (expired) begin
                    state <= RELEASE;
                    err_q <= 1'b1;
                end
                // Hold off until the slave drops ack
                RELEASE: if (!bus_ack) state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    // Command and read data
    always_ff @(posedge clk) begin
        if (state == IDLE && new_request) begin
            cmd_q <= '{addr: sub_req.addr, be: sub_req.be, wdata: sub_req.wdata,
                       we: sub_req.store};
            load_q <= sub_req.load;
        end
        if (state == REQ && bus_ack) begin
            rdata_q <= bus_rdata;
        end
    end

    assign bus_cmd = cmd_q;
    assign bus_req = (state == REQ);

    // Completion pulse for every access, error on timeout
    assign rsp.data_valid = (state == DONE);
    assign rsp.error = (state == DONE) & err_q;
    assign rsp.rdata = ((state == DONE) & load_q & ~err_q) ? rdata_q : '0;
    assign rsp.ready = (state == IDLE);

endmodule

//--- src/lsu_top.sv
`timescale 1ns/10ps

module lsu_top
    import lsu_config_pkg::*, lsu_types_pkg::*;
#(
    parameter int SCRATCH_WORDS = DEFAULT_SCRATCH_WORDS,
    parameter int INFLIGHT = DEFAULT_INFLIGHT,
    parameter int BUS_TIMEOUT = DEFAULT_BUS_TIMEOUT
) (
    input  logic          clk,
    input  logic          rst,
    input  ls_request_t   request,
    input  logic          request_valid,
    output logic          request_ready,
    output ls_writeback_t wb,
    output bus_cmd_t      bus_cmd,
    output logic          bus_req,
    input  logic          bus_ack,
    input  word_t         bus_rdata
);
    // Shared request, one strobe per target
    sub_request_t  sub_req;
    logic          scratch_new_request;
    logic          bus_new_request;
    sub_response_t scratch_rsp;
    sub_response_t bus_rsp;

    load_store_unit #(.INFLIGHT(INFLIGHT)) lsu (
        .clk(clk), .rst(rst), .request(request), .request_valid(request_valid),
        .request_ready(request_ready), .sub_req(sub_req),
        .scratch_new_request(scratch_new_request), .bus_new_request(bus_new_request),
        .scratch_rsp(scratch_rsp), .bus_rsp(bus_rsp), .wb(wb)
    );

    // On-chip RAM below the bus region
    scratch_mem #(.WORDS(SCRATCH_WORDS)) scratch (
        .clk(clk), .rst(rst), .sub_req(sub_req), .new_request(scratch_new_request),
        .rsp(scratch_rsp)
    );

    // External four-phase bus
    bus_master #(.TIMEOUT(BUS_TIMEOUT)) bus (
        .clk(clk), .rst(rst), .sub_req(sub_req), .new_request(bus_new_request),
        .rsp(bus_rsp), .bus_cmd(bus_cmd), .bus_req(bus_req), .bus_ack(bus_ack),
        .bus_rdata(bus_rdata)
    );

endmodule

//--- dv/bus_responder.sv
`timescale 1ns/10ps

module bus_responder
    import lsu_types_pkg::*;
#(
    parameter int WORDS = 64,
    parameter int DELAYS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  bus_cmd_t              bus_cmd,
    input  logic                  bus_req,
    output logic                  bus_ack,
    output word_t                 bus_rdata,
    input  logic                  withhold,
    input  logic [3*DELAYS-1:0]   delay_table
);
    localparam int IDX_W = $clog2(WORDS);

    typedef enum logic [1:0] {
        WAIT_REQ,
        DELAY,
        ACK_HIGH,
        IGNORE
    } phase_t;

    word_t            mem [WORDS];
    phase_t           phase;
    int               wait_left;
    int               accesses;
    logic [IDX_W-1:0] idx;

    // Word index inside the bus window
    assign idx = bus_cmd.addr[2 +: IDX_W];

    // Fill from each word's full bus address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (32'h8000_0000 | (32'(i) << 2)) * 32'h9e37_79b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase slave
    always @(posedge clk) begin
        if (rst) begin
            phase <= WAIT_REQ;
            bus_ack <= 1'b0;
            bus_rdata <= '0;
            wait_left <= 0;
            accesses <= 0;
        end else begin
            case (phase)
                // Next delay from the table, one entry per access
                WAIT_REQ: if (bus_req) begin
                    wait_left <= int'(delay_table[3*(accesses % DELAYS) +: 3]);
                    accesses <= accesses + 1;
                    phase <= withhold ? IGNORE : DELAY;
                end
                DELAY: if (wait_left > 0) begin
                    wait_left <= wait_left - 1;
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        if (bus_cmd.we && bus_cmd.be[i]) begin
                            mem[idx][8*i +: 8] <= bus_cmd.wdata[8*i +: 8];
                        end
                    end
                    bus_rdata <= mem[idx];
                    bus_ack <= 1'b1;
                    phase <= ACK_HIGH;
                end
                // Ack drops only after req is gone
                ACK_HIGH: if (!bus_req) begin
                    bus_ack <= 1'b0;
                    phase <= WAIT_REQ;
                end
                // Never acks, master has to time out
                default: if (!bus_req) phase <= WAIT_REQ;
            endcase
        end
    end

endmodule

//--- dv/tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu
    import lsu_config_pkg::*, lsu_types_pkg::*;
();
    localparam int CYCLE_LIMIT = 4000;

    logic          clk;
    logic          rst;
    ls_request_t   request;
    logic          request_valid;
    logic          request_ready;
    ls_writeback_t wb;
    bus_cmd_t      bus_cmd;
    logic          bus_req;
    logic          bus_ack;
    word_t         bus_rdata;
    logic          withhold;
    logic [191:0]  delay_table;

    // Reference state
    ls_writeback_t expect_q[$];
    ls_writeback_t head_exp;
    logic [7:0]    model_bytes [1280];
    word_t         last_load;
    int            next_id = 0;
    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;
    logic          req_prev = 1'b0;
    logic          ready_dropped = 1'b0;

    lsu_top #(
        .SCRATCH_WORDS(DEFAULT_SCRATCH_WORDS),
        .INFLIGHT(DEFAULT_INFLIGHT),
        .BUS_TIMEOUT(DEFAULT_BUS_TIMEOUT)
    ) dut (
        .clk(clk), .rst(rst), .request(request), .request_valid(request_valid),
        .request_ready(request_ready), .wb(wb), .bus_cmd(bus_cmd), .bus_req(bus_req),
        .bus_ack(bus_ack), .bus_rdata(bus_rdata)
    );

    bus_responder #(.WORDS(64), .DELAYS(64)) responder (
        .clk(clk), .rst(rst), .bus_cmd(bus_cmd), .bus_req(bus_req), .bus_ack(bus_ack),
        .bus_rdata(bus_rdata), .withhold(withhold), .delay_table(delay_table)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Byte-array model
    // Scratch bytes first and 64 bus words above them
    function automatic int byte_slot(input addr_t a);
        if (a[BUS_REGION_BIT]) begin
            byte_slot = 1024 + int'(a[7:0]);
        end else begin
            byte_slot = int'(a[9:0]);
        end
    endfunction

    function automatic logic is_misaligned(input addr_t a, input ls_width_t w);
        if (w == LS_W) begin
            is_misaligned = (a[1:0] != 2'b00);
        end else begin
            is_misaligned = (w == LS_H || w == LS_HU) ? a[0] : 1'b0;
        end
    endfunction

    function automatic word_t expected_load(input addr_t a, input ls_width_t w);
        logic [7:0] b0, b1, b2, b3;
        b0 = model_bytes[byte_slot(a)];
        b1 = model_bytes[byte_slot(a + 1)];
        b2 = model_bytes[byte_slot(a + 2)];
        b3 = model_bytes[byte_slot(a + 3)];
        case (w)
            LS_B: expected_load = {{24{b0[7]}}, b0};
            LS_BU: expected_load = {24'd0, b0};
            LS_H: expected_load = {{16{b1[7]}}, b1, b0};
            LS_HU: expected_load = {16'd0, b1, b0};
            default: expected_load = {b3, b2, b1, b0};
        endcase
    endfunction

    // Only the bytes covered by the width change
    function automatic void apply_store(input addr_t a, input ls_width_t w, input word_t d);
        int n;
        n = (w == LS_W) ? 4 : ((w == LS_H || w == LS_HU) ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            model_bytes[byte_slot(a + i)] = d[8*i +: 8];
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    // Queues the expected writeback and holds the request until taken
    task automatic access(input addr_t a, input ls_width_t w, input logic st,
                          input word_t d, input logic fwd);
        ls_writeback_t e;
        word_t src;
        e.id = ls_id_t'(next_id);
        e.done = 1'b1;
        e.rd = '0;
        e.error = is_misaligned(a, w) | (withhold & a[BUS_REGION_BIT]);
        src = fwd ? last_load : d;
        if (!e.error && st) begin
            apply_store(a, w, src);
        end else if (!e.error) begin
            e.rd = expected_load(a, w);
            last_load = e.rd;
        end
        expect_q.push_back(e);
        request = '{addr: a, store_data: d, width: w, id: e.id, load: !st, store: st,
                    forward: fwd};
        request_valid = 1'b1;
        // Ready is registered, so its value here holds for the coming edge
        while (!request_ready) begin
            ready_dropped = 1'b1;
            @(posedge clk);
            #0.5;
        end
        @(posedge clk);
        #0.5;
        request_valid = 1'b0;
        next_id++;
    endtask

    // Until every queued writeback came back
    task automatic wait_idle();
        while (expect_q.size() != 0) @(posedge clk);
        @(posedge clk);
        #0.5;
    endtask

    // Idle outputs straight out of reset
    task automatic check_reset_state();
        checks++;
        if (request_ready !== 1'b1 || bus_req !== 1'b0 || wb.done !== 1'b0) begin
            errors++;
            $display("CHECK FAILED t=%0t: after reset ready %b req %b done %b, expected 1 0 0",
                     $time, request_ready, bus_req, wb.done);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    task automatic scratch_word_roundtrip();
        addr_t addrs[4] = '{32'h0, 32'h40, 32'h124, 32'h3fc};
        for (int i = 0; i < 4; i++) begin
            access(addrs[i], LS_W, 1'b1, 32'hc0de_0000 ^ (addrs[i] * 32'h101), 1'b0);
            access(addrs[i], LS_W, 1'b0, '0, 1'b0);
        end
        wait_idle();
    endtask

    task automatic scratch_subword_lanes();
        access(32'h80, LS_W, 1'b1, 32'h8899_aabb, 1'b0);
        access(32'h84, LS_W, 1'b1, 32'h0, 1'b0);
        access(32'h88, LS_W, 1'b1, 32'hff00_7f80, 1'b0);
        for (int i = 0; i < 4; i++) begin
            access(32'h80 + i, LS_B, 1'b1, $urandom(), 1'b0);
        end
        for (int i = 0; i < 4; i += 2) begin
            access(32'h84 + i, LS_H, 1'b1, $urandom(), 1'b0);
        end
        // One lane of a word with both sign patterns
        access(32'h89, LS_B, 1'b1, 32'hffff_ff01, 1'b0);
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 4; i++) begin
                access(32'h80 + 4*k + i, LS_B, 1'b0, '0, 1'b0);
                access(32'h80 + 4*k + i, LS_BU, 1'b0, '0, 1'b0);
            end
            for (int i = 0; i < 4; i += 2) begin
                access(32'h80 + 4*k + i, LS_H, 1'b0, '0, 1'b0);
                access(32'h80 + 4*k + i, LS_HU, 1'b0, '0, 1'b0);
            end
            access(32'h80 + 4*k, LS_W, 1'b0, '0, 1'b0);
        end
        wait_idle();
    endtask

    task automatic bus_random_delay();
        ready_dropped = 1'b0;
        access(32'h8000_0020, LS_W, 1'b1, $urandom(), 1'b0);
        access(32'h8000_0024, LS_W, 1'b1, $urandom(), 1'b0);
        access(32'h8000_0025, LS_B, 1'b1, $urandom(), 1'b0);
        access(32'h8000_0026, LS_H, 1'b1, $urandom(), 1'b0);
        access(32'h8000_0020, LS_W, 1'b0, '0, 1'b0);
        access(32'h8000_0024, LS_W, 1'b0, '0, 1'b0);
        access(32'h8000_0021, LS_B, 1'b0, '0, 1'b0);
        access(32'h8000_0027, LS_BU, 1'b0, '0, 1'b0);
        access(32'h8000_0022, LS_H, 1'b0, '0, 1'b0);
        access(32'h8000_0026, LS_HU, 1'b0, '0, 1'b0);
        wait_idle();
        // Back-to-back bus accesses fill the input queue
        checks++;
        if (!ready_dropped) begin
            errors++;
            $display("CHECK FAILED t=%0t: request_ready never dropped under bus back-pressure",
                     $time);
        end
        // Slave memory against the model
        for (int i = 8; i < 10; i++) begin
            checks++;
            if (responder.mem[i] !== expected_load(32'h8000_0000 + 4*i, LS_W)) begin
                errors++;
                $display("CHECK FAILED t=%0t: bus word %0d holds %h, expected %h", $time, i,
                         responder.mem[i], expected_load(32'h8000_0000 + 4*i, LS_W));
            end
        end
    endtask

    task automatic mixed_order_forward();
        access(32'h100, LS_W, 1'b1, 32'h1357_9bdf, 1'b0);
        access(32'h8000_0040, LS_W, 1'b1, 32'h2468_ace0, 1'b0);
        access(32'h100, LS_W, 1'b0, '0, 1'b0);
        access(32'h8000_0040, LS_H, 1'b0, '0, 1'b0);
        // Sign-extended halfword goes out as a whole word
        access(32'h104, LS_W, 1'b1, '0, 1'b1);
        access(32'h101, LS_B, 1'b0, '0, 1'b0);
        access(32'h8000_0044, LS_H, 1'b1, '0, 1'b1);
        access(32'h104, LS_W, 1'b0, '0, 1'b0);
        access(32'h8000_0044, LS_HU, 1'b0, '0, 1'b0);
        wait_idle();
    endtask

    task automatic misaligned_no_access();
        access(32'h90, LS_W, 1'b1, 32'h0bad_f00d, 1'b0);
        access(32'h91, LS_H, 1'b1, 32'hffff_ffff, 1'b0);
        access(32'h92, LS_W, 1'b1, 32'h1111_2222, 1'b0);
        access(32'h93, LS_HU, 1'b0, '0, 1'b0);
        access(32'h8000_0022, LS_W, 1'b1, 32'h3333_4444, 1'b0);
        access(32'h90, LS_W, 1'b0, '0, 1'b0);
        access(32'h8000_0020, LS_W, 1'b0, '0, 1'b0);
        wait_idle();
    endtask

    task automatic bus_ack_timeout();
        withhold = 1'b1;
        access(32'h8000_0020, LS_W, 1'b0, '0, 1'b0);
        wait_idle();
        withhold = 1'b0;
        // Bus has to recover after the expiry
        access(32'h8000_0024, LS_W, 1'b1, $urandom(), 1'b0);
        access(32'h8000_0024, LS_W, 1'b0, '0, 1'b0);
        access(32'h90, LS_W, 1'b0, '0, 1'b0);
        wait_idle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback order and bus handshake monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (bus_req && !req_prev && bus_ack) begin
                errors++;
                $display("Bus protocol broken at %0t: req raised while ack still high", $time);
            end
            req_prev = bus_req;
            if (wb.done && expect_q.size() == 0) begin
                errors++;
                $display("Writeback with id %0d at %0t was not expected", wb.id, $time);
            end else if (wb.done) begin
                head_exp = expect_q.pop_front();
                checks++;
                if (wb.id !== head_exp.id || wb.rd !== head_exp.rd
                        || wb.error !== head_exp.error) begin
                    errors++;
                    $display("CHECK FAILED t=%0t: wb id %0d rd %h err %b, expected %0d %h %b",
                             $time, wb.id, wb.rd, wb.error, head_exp.id, head_exp.rd,
                             head_exp.error);
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, DUT stopped responding", CYCLE_LIMIT);
            $display("Summary: %0d checks, %0d errors", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(85530));
        clk = 1'b0;
        rst = 1'b1;
        request = '0;
        request_valid = 1'b0;
        withhold = 1'b0;
        // Ack delays of 0 to 5 cycles
        for (int i = 0; i < 64; i++) begin
            delay_table[3*i +: 3] = 3'($urandom_range(5, 0));
        end
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;
        check_reset_state();
        scratch_word_roundtrip();
        scratch_subword_lanes();
        bus_random_delay();
        mixed_order_forward();
        misaligned_no_access();
        bus_ack_timeout();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
src/lsu_config_pkg.sv
src/lsu_types_pkg.sv
src/lsu_fifo.sv
src/bus_timeout_timer.sv
src/load_store_unit.sv
src/scratch_mem.sv
src/bus_master.sv
src/lsu_top.sv
dv/bus_responder.sv
dv/tb_lsu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 --top-module tb_lsu -f build.f -o sim_lsu
./obj_dir/sim_lsu | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"
